// ==== hdl/ib_fifo_settings.svh ====
// queue depth and field widths, included by every RTL file and the testbench
`ifndef IB_FIFO_SETTINGS_SVH
`define IB_FIFO_SETTINGS_SVH

// number of replay slots
// admission checks slots 7 and 6 directly, so keep this at 8
`define IB_DEPTH 8

`define IB_INSTR_W 32 // full 32b encodings only

// narrowed program counter
`define IB_PC_W 32

`endif

// ==== hdl/ib_fifo_pkg.sv ====
// shared types for the replay queue, imported by the RTL modules and the testbench
`default_nettype none

`include "ib_fifo_settings.svh"

package ib_fifo_pkg;

   // one slot, instruction in the upper half
   typedef struct packed {
      logic [`IB_INSTR_W-1:0] instr;
      logic [`IB_PC_W-1:0]    pc;
   } ib_entry_t;

   // controller state
   typedef enum logic [1:0] {
      MODE_IDLE   = 2'd0, // queue unused, decode runs from the buffer
      MODE_FILL   = 2'd1, // capturing dependent instructions
      MODE_REPLAY = 2'd2  // feeding decode from the slots
   } fifo_mode_e;

   // per-cycle slot array operation
   typedef enum logic [1:0] {
      SHIFT_NONE = 2'd0,
      SHIFT_ONE  = 2'd1, // i0 consumed
      SHIFT_TWO  = 2'd2  // i0 and i1 consumed
   } shift_e;

endpackage

`default_nettype wire

// ==== hdl/ib_slot_if.sv ====
// slot control bundle from the queue controller to the slot array
`default_nettype none

`include "ib_fifo_settings.svh"

interface ib_slot_if
   import ib_fifo_pkg::*;
();

   logic [`IB_DEPTH-1:0] wr_i0_sel;  // slot taking i0, at most one bit
   logic [`IB_DEPTH-1:0] wr_i1_sel;  // slot taking i1
   shift_e               shift_op;
   logic [`IB_DEPTH-1:0] slot_valid; // registered valids, also gate the shift enables

   modport ctl (
      output wr_i0_sel,
      output wr_i1_sel,
      output shift_op,
      output slot_valid
   );

   // array side only listens
   modport array (
      input wr_i0_sel,
      input wr_i1_sel,
      input shift_op,
      input slot_valid
   );

endinterface

`default_nettype wire

// ==== hdl/ib_fifo_ctl.sv ====
// replay queue controller: mode FSM, slot valids, write placement and replay shift choice
`default_nettype none

`include "ib_fifo_settings.svh"

module ib_fifo_ctl
   import ib_fifo_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,

   input  logic       i0_decode,     // offer in fill, consume in replay
   input  logic       i1_decode,
   input  logic       i0_load_block, // dependency on a predicted load
   input  logic       i1_load_block,
   input  logic       i0_vp_flush,   // value mispredict at check stage
   input  logic       i1_vp_flush,
   input  logic       i0_load_match, // blocking load at check stage
   input  logic       i1_load_match,

   output logic       replay,
   output logic [1:0] head_valid,
   output logic       fifo_empty,

   ib_slot_if.ctl     slots
);

   fifo_mode_e           mode_q;
   fifo_mode_e           mode_d;
   logic [`IB_DEPTH-1:0] valid_q;
   logic [`IB_DEPTH-1:0] valid_d;
   logic [`IB_DEPTH-1:0] valid_shifted;
   logic [`IB_DEPTH-1:0] first_empty;
   logic [`IB_DEPTH-1:0] i0_sel;
   logic [`IB_DEPTH-1:0] i1_sel;
   logic                 resolve;
   logic                 mispredict;
   logic                 load_block;
   logic                 fill_en;
   logic                 i0_acc;
   logic                 i1_acc;
   shift_e               shift_op;

   // prediction was right on some lane
   assign resolve    = (i0_load_match & ~i0_vp_flush) | (i1_load_match & ~i1_vp_flush);
   assign mispredict = (i0_vp_flush | i1_vp_flush) & ~resolve;
   assign load_block = i0_load_block | i1_load_block;

   // offers count in fill and on the cycle that enters fill,
   // never in a resolve or mispredict cycle
   assign fill_en = ((mode_q == MODE_FILL) || (mode_q == MODE_IDLE && load_block))
                    && !resolve && !mispredict;

   assign i0_acc = i0_decode & ~valid_q[`IB_DEPTH-1] & fill_en;
   assign i1_acc = i1_decode & ~valid_q[`IB_DEPTH-2] & fill_en;

   // valids are packed from slot 0, so the first hole is one-hot
   assign first_empty = ~valid_q & {valid_q[`IB_DEPTH-2:0], 1'b1};

   assign i0_sel = i0_acc ? first_empty : '0;

   // i1 lands behind i0 when both go in, alone it takes the first hole
   always_comb begin
      i1_sel = '0;
      if (i1_acc) begin
         if (i0_acc) begin
            i1_sel = first_empty << 1; // slot 6 free here, so no overflow
         end else begin
            i1_sel = first_empty;
         end
      end
   end

   // consumption reported by decode during replay
   always_comb begin
      shift_op = SHIFT_NONE;
      if (mode_q == MODE_REPLAY) begin
         if (i0_decode && i1_decode) begin
            shift_op = SHIFT_TWO;
         end else if (i0_decode) begin
            shift_op = SHIFT_ONE;
         end
      end
   end

   always_comb begin
      case (shift_op)
         SHIFT_ONE: valid_shifted = valid_q >> 1;
         SHIFT_TWO: valid_shifted = valid_q >> 2;
         default:   valid_shifted = valid_q;
      endcase
   end

   assign valid_d = resolve ? '0 : (valid_shifted | i0_sel | i1_sel);

   // mode FSM
   always_comb begin
      mode_d = mode_q;
      if (resolve) begin
         mode_d = MODE_IDLE; // good prediction drops everything
      end else begin
         case (mode_q)
            MODE_IDLE: begin
               if (load_block && !mispredict) begin
                  mode_d = MODE_FILL;
               end
            end
            MODE_FILL: begin
               if (mispredict) begin
                  mode_d = (|valid_q) ? MODE_REPLAY : MODE_IDLE;
               end
            end
            MODE_REPLAY: begin
               if (valid_shifted == '0) begin
                  mode_d = MODE_IDLE; // last entries leave at this edge
               end
            end
            default: mode_d = MODE_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mode_q  <= MODE_IDLE;
         valid_q <= '0;
      end else begin
         mode_q  <= mode_d;
         valid_q <= valid_d;
      end
   end

   assign slots.wr_i0_sel  = i0_sel;
   assign slots.wr_i1_sel  = i1_sel;
   assign slots.shift_op   = shift_op;
   assign slots.slot_valid = valid_q;

   assign replay     = (mode_q == MODE_REPLAY);
   assign head_valid = valid_q[1:0];
   assign fifo_empty = ~|valid_q;

   // placement and shifting together must keep the valids as a solid run from slot 0
   a_valid_contiguous: assert property (@(posedge clk) disable iff (!arst_n)
      ((valid_q + 1'b1) & valid_q) == '0);

   // decode takes slot 1 only after slot 0
   a_replay_in_order: assert property (@(posedge clk) disable iff (!arst_n)
      (mode_q == MODE_REPLAY) |-> !(i1_decode && !i0_decode));

endmodule

`default_nettype wire

// ==== hdl/ib_slot_array.sv ====
// eight shifting entry registers that hold the captured instructions in program order
`default_nettype none

`include "ib_fifo_settings.svh"

module ib_slot_array
   import ib_fifo_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,

   input  ib_entry_t in_i0,
   input  ib_entry_t in_i1,

   ib_slot_if.array  slots,

   output ib_entry_t head0,
   output ib_entry_t head1
);

   // two zero pads above the top slot keep the shift sources uniform
   ib_entry_t              slot_q [`IB_DEPTH+2];
   logic [`IB_DEPTH+1:0]   src_valid;
   logic [`IB_DEPTH-1:0]   slot_load;

   assign src_valid = {2'b00, slots.slot_valid};

   assign slot_q[`IB_DEPTH]   = '0;
   assign slot_q[`IB_DEPTH+1] = '0;

   for (genvar k = 0; k < `IB_DEPTH; k++) begin : g_slot
      ib_entry_t entry_q;
      ib_entry_t entry_d;
      logic      sh1_en;
      logic      sh2_en;

      // only move entries that hold something
      assign sh1_en = (slots.shift_op == SHIFT_ONE) && src_valid[k+1];
      assign sh2_en = (slots.shift_op == SHIFT_TWO) && src_valid[k+2];

      assign slot_load[k] = slots.wr_i0_sel[k] | slots.wr_i1_sel[k] | sh1_en | sh2_en;

      // writes and shifts never meet, fill and replay are separate modes
      always_comb begin
         if (slots.wr_i0_sel[k]) begin
            entry_d = in_i0;
         end else if (slots.wr_i1_sel[k]) begin
            entry_d = in_i1;
         end else if (sh2_en) begin
            entry_d = slot_q[k+2];
         end else begin
            entry_d = slot_q[k+1];
         end
      end

      always_ff @(posedge clk) begin
         if (slot_load[k]) begin
            entry_q <= entry_d;
         end
      end

      assign slot_q[k] = entry_q;
   end

   assign head0 = slot_q[0];
   assign head1 = slot_q[1];

   // controller must hand out distinct single slots per lane
   a_wr_sel_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(slots.wr_i0_sel) && $onehot0(slots.wr_i1_sel)
      && ((slots.wr_i0_sel & slots.wr_i1_sel) == '0));

endmodule

`default_nettype wire

// ==== hdl/ib_fifo_top.sv ====
// replay queue top level with plain ports, joins the controller and the slot array
`default_nettype none

`include "ib_fifo_settings.svh"

module ib_fifo_top
   import ib_fifo_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,

   input  logic                   i0_decode,
   input  logic                   i1_decode,
   input  logic                   i0_load_block,
   input  logic                   i1_load_block,
   input  logic                   i0_vp_flush,
   input  logic                   i1_vp_flush,
   input  logic                   i0_load_match,
   input  logic                   i1_load_match,

   input  logic [`IB_INSTR_W-1:0] i0_instr,
   input  logic [`IB_INSTR_W-1:0] i1_instr,
   input  logic [`IB_PC_W-1:0]    i0_pc,
   input  logic [`IB_PC_W-1:0]    i1_pc,

   output logic                   replay,
   output logic                   fifo_i0_valid,
   output logic                   fifo_i1_valid,
   output logic [`IB_INSTR_W-1:0] fifo_i0_instr,
   output logic [`IB_INSTR_W-1:0] fifo_i1_instr,
   output logic [`IB_PC_W-1:0]    fifo_i0_pc,
   output logic [`IB_PC_W-1:0]    fifo_i1_pc,
   output logic                   fifo_empty
);

   ib_slot_if slots_if ();

   ib_entry_t  in_i0;
   ib_entry_t  in_i1;
   ib_entry_t  head0;
   ib_entry_t  head1;
   logic [1:0] head_valid;

   assign in_i0 = '{instr: i0_instr, pc: i0_pc};
   assign in_i1 = '{instr: i1_instr, pc: i1_pc};

   ib_fifo_ctl u_ctl (
      .clk           (clk),
      .arst_n        (arst_n),
      .i0_decode     (i0_decode),
      .i1_decode     (i1_decode),
      .i0_load_block (i0_load_block),
      .i1_load_block (i1_load_block),
      .i0_vp_flush   (i0_vp_flush),
      .i1_vp_flush   (i1_vp_flush),
      .i0_load_match (i0_load_match),
      .i1_load_match (i1_load_match),
      .replay        (replay),
      .head_valid    (head_valid),
      .fifo_empty    (fifo_empty),
      .slots         (slots_if)
   );

   ib_slot_array u_array (
      .clk    (clk),
      .arst_n (arst_n),
      .in_i0  (in_i0),
      .in_i1  (in_i1),
      .slots  (slots_if),
      .head0  (head0),
      .head1  (head1)
   );

   // heads go to decode as slot 0 and slot 1
   assign fifo_i0_valid = head_valid[0];
   assign fifo_i1_valid = head_valid[1];
   assign fifo_i0_instr = head0.instr;
   assign fifo_i1_instr = head1.instr;
   assign fifo_i0_pc    = head0.pc;
   assign fifo_i1_pc    = head1.pc;

endmodule

`default_nettype wire

// ==== tb/tb_ib_fifo.sv ====
// testbench for the replay queue, runs fill, replay, overflow and resolve cases against a queue model
`default_nettype none

`include "ib_fifo_settings.svh"

module tb_ib_fifo
   import ib_fifo_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int          CLK_PERIOD   = 40;
   localparam int          RESET_CYCLES = 4;
   localparam int          DRIVE_DELAY  = 2;
   localparam int          RISE_LIMIT   = 8;
   localparam int          DRAIN_LIMIT  = 40;
   localparam logic [31:0] INSTR_BASE   = 32'h0c0d_e000;

   logic                   clk;
   logic                   arst_n;
   logic                   i0_decode;
   logic                   i1_decode;
   logic                   i0_load_block;
   logic                   i1_load_block;
   logic                   i0_vp_flush;
   logic                   i1_vp_flush;
   logic                   i0_load_match;
   logic                   i1_load_match;
   logic [`IB_INSTR_W-1:0] i0_instr;
   logic [`IB_INSTR_W-1:0] i1_instr;
   logic [`IB_PC_W-1:0]    i0_pc;
   logic [`IB_PC_W-1:0]    i1_pc;
   logic                   replay;
   logic                   fifo_i0_valid;
   logic                   fifo_i1_valid;
   logic [`IB_INSTR_W-1:0] fifo_i0_instr;
   logic [`IB_INSTR_W-1:0] fifo_i1_instr;
   logic [`IB_PC_W-1:0]    fifo_i0_pc;
   logic [`IB_PC_W-1:0]    fifo_i1_pc;
   logic                   fifo_empty;

   integer                 seed = 1;
   int                     instr_seq = 0;

   // reference model, updated at each rising edge
   ib_entry_t              exp_q[$];
   fifo_mode_e             m_mode = MODE_IDLE;
   logic                   m_has_entries = 1'b0;
   logic                   res_now;
   logic                   mis_now;

   assign res_now = (i0_load_match && !i0_vp_flush) || (i1_load_match && !i1_vp_flush);
   assign mis_now = (i0_vp_flush || i1_vp_flush) && !res_now;

   ib_fifo_top u_dut (
      .clk           (clk),
      .arst_n        (arst_n),
      .i0_decode     (i0_decode),
      .i1_decode     (i1_decode),
      .i0_load_block (i0_load_block),
      .i1_load_block (i1_load_block),
      .i0_vp_flush   (i0_vp_flush),
      .i1_vp_flush   (i1_vp_flush),
      .i0_load_match (i0_load_match),
      .i1_load_match (i1_load_match),
      .i0_instr      (i0_instr),
      .i1_instr      (i1_instr),
      .i0_pc         (i0_pc),
      .i1_pc         (i1_pc),
      .replay        (replay),
      .fifo_i0_valid (fifo_i0_valid),
      .fifo_i1_valid (fifo_i1_valid),
      .fifo_i0_instr (fifo_i0_instr),
      .fifo_i1_instr (fifo_i1_instr),
      .fifo_i0_pc    (fifo_i0_pc),
      .fifo_i1_pc    (fifo_i1_pc),
      .fifo_empty    (fifo_empty)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("*** FAILED ***");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
      abort_run($sformatf("error at %0d ns: %s is %0h, expected %0h", $time, name, got, want));
   endtask

   // slot 7 gates i0, slot 6 gates i1, both against the count before this cycle
   task automatic admit_offers();
      int        n;
      ib_entry_t e;
      n = exp_q.size();
      if (i0_decode && n < `IB_DEPTH) begin
         e.instr = i0_instr;
         e.pc    = i0_pc;
         exp_q.push_back(e);
      end
      if (i1_decode && n < `IB_DEPTH - 1) begin
         e.instr = i1_instr;
         e.pc    = i1_pc;
         exp_q.push_back(e);
      end
   endtask

   task automatic retire_consumed();
      if (i0_decode && exp_q.size() > 0) void'(exp_q.pop_front());
      if (i0_decode && i1_decode && exp_q.size() > 0) void'(exp_q.pop_front());
   endtask

   task automatic model_step();
      if (res_now) begin
         exp_q.delete();
         m_mode = MODE_IDLE;
      end else begin
         case (m_mode)
            MODE_IDLE: begin
               if ((i0_load_block || i1_load_block) && !mis_now) begin
                  admit_offers(); // entering cycle already captures
                  m_mode = MODE_FILL;
               end
            end
            MODE_FILL: begin
               if (mis_now) begin
                  m_mode = (exp_q.size() != 0) ? MODE_REPLAY : MODE_IDLE;
               end else begin
                  admit_offers();
               end
            end
            MODE_REPLAY: begin
               retire_consumed();
               if (exp_q.size() == 0) m_mode = MODE_IDLE;
            end
            default: m_mode = MODE_IDLE;
         endcase
      end
   endtask

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         exp_q.delete();
         m_mode = MODE_IDLE;
      end else begin
         model_step();
      end
      m_has_entries = (exp_q.size() != 0);
   end

   // outputs compared at the falling edge, well away from drive and update
   always @(negedge clk) begin
      ib_entry_t h0;
      ib_entry_t h1;
      logic      exp_replay;
      h0 = '0;
      h1 = '0;
      exp_replay = (m_mode == MODE_REPLAY);
      if (exp_q.size() > 0) h0 = exp_q[0];
      if (exp_q.size() > 1) h1 = exp_q[1];
      if (arst_n) begin
         a_replay: assert (replay == exp_replay)
            else report_mismatch("replay", 32'(replay), 32'(exp_replay));
         a_empty: assert (fifo_empty == (exp_q.size() == 0))
            else report_mismatch("fifo_empty", 32'(fifo_empty), 32'(exp_q.size() == 0));
         a_i0_valid: assert (fifo_i0_valid == (exp_q.size() > 0))
            else report_mismatch("fifo_i0_valid", 32'(fifo_i0_valid), 32'(exp_q.size() > 0));
         a_i1_valid: assert (fifo_i1_valid == (exp_q.size() > 1))
            else report_mismatch("fifo_i1_valid", 32'(fifo_i1_valid), 32'(exp_q.size() > 1));
         if (exp_q.size() > 0) begin
            a_i0_instr: assert (fifo_i0_instr == h0.instr)
               else report_mismatch("fifo_i0_instr", fifo_i0_instr, h0.instr);
            a_i0_pc: assert (fifo_i0_pc == h0.pc)
               else report_mismatch("fifo_i0_pc", fifo_i0_pc, h0.pc);
         end
         if (exp_q.size() > 1) begin
            a_i1_instr: assert (fifo_i1_instr == h1.instr)
               else report_mismatch("fifo_i1_instr", fifo_i1_instr, h1.instr);
            a_i1_pc: assert (fifo_i1_pc == h1.pc)
               else report_mismatch("fifo_i1_pc", fifo_i1_pc, h1.pc);
         end
      end
   end

   a_replay_follows_mispredict: assert property (@(negedge clk) disable iff (!arst_n)
      (mis_now && m_mode == MODE_FILL && m_has_entries) |=> replay)
      else abort_run("replay did not rise one cycle after a mispredict with entries");

   a_resolve_clears: assert property (@(negedge clk) disable iff (!arst_n)
      res_now |=> (fifo_empty && !fifo_i0_valid && !fifo_i1_valid && !replay))
      else abort_run("queue was not cleared one cycle after a resolve");

   a_quiet_mispredict: assert property (@(negedge clk) disable iff (!arst_n)
      (mis_now && (m_mode == MODE_IDLE || !m_has_entries)) |=> !replay)
      else abort_run("replay rose after a mispredict with no fill or no entries");

   task automatic end_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
      i0_decode     = 1'b0; // strobes last one cycle
      i1_decode     = 1'b0;
      i0_load_block = 1'b0;
      i1_load_block = 1'b0;
      i0_vp_flush   = 1'b0;
      i1_vp_flush   = 1'b0;
      i0_load_match = 1'b0;
      i1_load_match = 1'b0;
   endtask

   // blk_lane 0 none, 1 on i0, 2 on i1
   task automatic offer(input logic take0, input logic take1, input int blk_lane);
      i0_decode     = take0;
      i1_decode     = take1;
      i0_load_block = (blk_lane == 1);
      i1_load_block = (blk_lane == 2);
      i0_instr      = INSTR_BASE + instr_seq;
      i1_instr      = INSTR_BASE + instr_seq + 1;
      i0_pc         = $random(seed);
      i1_pc         = $random(seed);
      instr_seq     = instr_seq + 2;
      end_cycle();
   endtask

   // an i0 offer rides along and must be dropped
   task automatic pulse_mispredict(input int lane);
      i0_load_match = (lane == 0);
      i0_vp_flush   = (lane == 0);
      i1_load_match = (lane == 1);
      i1_vp_flush   = (lane == 1);
      i0_decode     = 1'b1;
      i0_pc         = $random(seed);
      end_cycle();
   endtask

   task automatic pulse_resolve();
      i1_load_match = 1'b1;
      end_cycle();
   endtask

   task automatic consume(input int n);
      i0_decode = (n >= 1);
      i1_decode = (n == 2);
      end_cycle();
   endtask

   task automatic wait_replay_high();
      int n;
      n = 0;
      while (!replay && n < RISE_LIMIT) begin
         end_cycle();
         n++;
      end
      if (!replay) abort_run("timeout waiting for replay to rise");
   endtask

   // cycles through consume counts c0, c1, c2 until replay falls
   task automatic drain_replay(input int c0, input int c1, input int c2);
      int n;
      n = 0;
      while (replay && n < DRAIN_LIMIT) begin
         consume((n % 3 == 0) ? c0 : ((n % 3 == 1) ? c1 : c2));
         n++;
      end
      if (replay) abort_run("timeout waiting for replay to fall");
   endtask

   initial begin
      arst_n   = 1'b0;
      i0_instr = '0;
      i1_instr = '0;
      i0_pc    = '0;
      i1_pc    = '0;
      i0_decode     = 1'b0;
      i1_decode     = 1'b0;
      i0_load_block = 1'b0;
      i1_load_block = 1'b0;
      i0_vp_flush   = 1'b0;
      i1_vp_flush   = 1'b0;
      i0_load_match = 1'b0;
      i1_load_match = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      arst_n = 1'b1;
      repeat (3) end_cycle();

      // five entries, replay consuming two, none, one
      offer(1'b1, 1'b1, 1);
      offer(1'b1, 1'b0, 0);
      offer(1'b1, 1'b1, 0);
      pulse_mispredict(0);
      wait_replay_high();
      drain_replay(2, 0, 1);
      repeat (2) end_cycle();

      // lone i1 goes behind what is already held
      offer(1'b1, 1'b1, 2);
      offer(1'b0, 1'b1, 0);
      offer(1'b1, 1'b0, 0);
      offer(1'b0, 1'b1, 0);
      pulse_mispredict(1);
      wait_replay_high();
      drain_replay(1, 1, 1);
      repeat (2) end_cycle();

      // twelve offers into eight slots
      offer(1'b1, 1'b1, 1);
      offer(1'b1, 1'b0, 0);
      offer(1'b1, 1'b1, 0);
      offer(1'b1, 1'b1, 0);
      offer(1'b1, 1'b1, 0); // n=7, only i0 fits
      offer(1'b1, 1'b1, 0);
      offer(1'b0, 1'b1, 0);
      pulse_mispredict(0);
      wait_replay_high();
      drain_replay(2, 2, 2);
      repeat (2) end_cycle();

      // resolve drops the fill, next fill replays alone
      offer(1'b1, 1'b1, 1);
      offer(1'b1, 1'b0, 0);
      pulse_resolve();
      repeat (2) end_cycle();
      offer(1'b1, 1'b1, 2);
      pulse_mispredict(1);
      wait_replay_high();
      drain_replay(2, 1, 2);
      repeat (2) end_cycle();

      // mispredict while idle, then on an empty fill
      pulse_mispredict(0);
      repeat (2) end_cycle();
      offer(1'b0, 1'b0, 1);
      pulse_mispredict(1);
      repeat (3) end_cycle();

      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/ib_fifo_pkg.sv
hdl/ib_slot_if.sv
hdl/ib_fifo_ctl.sv
hdl/ib_slot_array.sv
hdl/ib_fifo_top.sv
tb/tb_ib_fifo.sv

// ==== Makefile ====
# Verilator build and run of the replay queue testbench

VERILATOR ?= verilator
TOP       ?= tb_ib_fifo
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

SRCS := $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '*** FAILED ***' $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
